// File: verilog/valu_pkg.sv
/*
 * Shared widths, RVV field constants and bus structs of the vector ALU pipe
 * Lane word union decoded per element width
 */
package valu_pkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int DLEN_W   = 128;                      // Datapath bits per step
  localparam int LANE_W   = 64;                       // One lane word
  localparam int LANE_NUM = DLEN_W / LANE_W;
  localparam int VLEN_W   = 256;                      // Vector register width
  localparam int STEP_W   = $clog2(VLEN_W / DLEN_W);  // Step index and pos width
  localparam int VL_W     = 9;
  localparam int RNID_W   = 6;                        // Physical register id
  localparam int CMT_ID_W = 6;

  // Element width code as in vtype.vsew
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_t;

  typedef enum logic [3:0] {
    OP_NONE  = 4'd0,  // Unknown encoding, done report only
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_MSEQ  = 4'd6,  // Mask producing compares
    OP_MSNE  = 4'd7,
    OP_MSLTU = 4'd8
  } alu_op_t;

  // RVV OPIVV / OPIVX encoding fields
  localparam logic [5:0] FUNCT6_VADD   = 6'b000000;
  localparam logic [5:0] FUNCT6_VSUB   = 6'b000010;
  localparam logic [5:0] FUNCT6_VAND   = 6'b001001;
  localparam logic [5:0] FUNCT6_VOR    = 6'b001010;
  localparam logic [5:0] FUNCT6_VXOR   = 6'b001011;
  localparam logic [5:0] FUNCT6_VMSEQ  = 6'b011000;
  localparam logic [5:0] FUNCT6_VMSNE  = 6'b011001;
  localparam logic [5:0] FUNCT6_VMSLTU = 6'b011010;
  localparam logic [2:0] FUNCT3_OPIVV  = 3'b000;
  localparam logic [2:0] FUNCT3_OPIVX  = 3'b100;

  // ------------------------------------------------------------------------
  // Bus structs
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic                valid;
    logic [31:0]         inst;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [RNID_W-1:0]   vs1_rnid;
    logic [RNID_W-1:0]   vs2_rnid;
    logic [RNID_W-1:0]   vd_rnid;
    logic [63:0]         scalar;   // rs1 value for .vx forms
    sew_t                sew;
    logic [VL_W-1:0]     vl;
    logic [STEP_W-1:0]   step;     // Slice of the register handled by this issue
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rnid;
    logic [STEP_W-1:0] pos;
  } vreg_rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rnid;
    logic [STEP_W-1:0] pos;
    logic [DLEN_W-1:0] data;
  } vreg_wr_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
  } done_rpt_t;

  // Same lane word seen as elements of each width
  typedef union packed {
    logic [7:0][7:0]   e8;
    logic [3:0][15:0]  e16;
    logic [1:0][31:0]  e32;
    logic [LANE_W-1:0] e64;
  } lane_word_u;

endpackage

// File: verilog/valu_decoder.sv
/*
 * Instruction decode for the integer vector ALU
 */
module valu_decoder (
  input  logic [31:0]       i_inst,
  output valu_pkg::alu_op_t o_op,
  output logic              o_is_mask,
  output logic              o_is_vx
);
  import valu_pkg::*;

  logic [5:0] w_funct6;
  logic [2:0] w_funct3;
  logic       w_opiv;  // Integer vv or vx category

  assign w_funct6 = i_inst[31:26];
  assign w_funct3 = i_inst[14:12];
  assign w_opiv   = (w_funct3 == FUNCT3_OPIVV) | (w_funct3 == FUNCT3_OPIVX);
  assign o_is_vx  = (w_funct3 == FUNCT3_OPIVX);  // Operand 1 taken from scalar

  always_comb begin
    o_op = OP_NONE;
    if (w_opiv) begin
      case (w_funct6)
        FUNCT6_VADD   : o_op = OP_ADD;
        FUNCT6_VSUB   : o_op = OP_SUB;
        FUNCT6_VAND   : o_op = OP_AND;
        FUNCT6_VOR    : o_op = OP_OR;
        FUNCT6_VXOR   : o_op = OP_XOR;
        FUNCT6_VMSEQ  : o_op = OP_MSEQ;
        FUNCT6_VMSNE  : o_op = OP_MSNE;
        FUNCT6_VMSLTU : o_op = OP_MSLTU;
        default       : o_op = OP_NONE;
      endcase
    end
  end

  // Compares write a mask register
  assign o_is_mask = (o_op == OP_MSEQ) | (o_op == OP_MSNE) | (o_op == OP_MSLTU);

endmodule

// File: verilog/valu_lane.sv
/*
 * One 64-bit lane of the vector ALU
 * Element ops for all widths, tail merge by vl, per-element compare bits
 */
module valu_lane (
  input  valu_pkg::alu_op_t         i_op,
  input  valu_pkg::sew_t            i_sew,
  input  valu_pkg::lane_word_u      i_vs1,
  input  valu_pkg::lane_word_u      i_vs2,
  input  valu_pkg::lane_word_u      i_old,
  input  logic [63:0]               i_scalar,
  input  logic                      i_is_vx,
  input  logic [valu_pkg::VL_W-1:0] i_elem_base,  // Global index of element 0
  input  logic [valu_pkg::VL_W-1:0] i_vl,
  output valu_pkg::lane_word_u      o_res,
  output logic [7:0]                o_cmp
);
  import valu_pkg::*;

  // One element on zero-extended operands, bit 64 is the compare outcome
  function automatic logic [64:0] elem_op(input alu_op_t op, input logic [63:0] a,
                                          input logic [63:0] b);
    logic [63:0] r;
    logic        c;
    r = '0;
    c = 1'b0;
    case (op)
      OP_ADD   : r = a + b;
      OP_SUB   : r = a - b;  // vs2 - vs1
      OP_AND   : r = a & b;
      OP_OR    : r = a | b;
      OP_XOR   : r = a ^ b;
      OP_MSEQ  : c = (a == b);
      OP_MSNE  : c = (a != b);
      OP_MSLTU : c = (a < b);  // Unsigned since both sides are zero-extended
      default  : r = '0;
    endcase
    return {c, r};
  endfunction

  always_comb begin
    logic [64:0] ext;
    o_res = i_old;  // Tail elements keep old vd
    o_cmp = '0;
    ext   = '0;
    unique case (i_sew)
      EW8 : begin
        for (int i = 0; i < 8; i++) begin
          ext = elem_op(i_op, 64'(i_vs2.e8[i]),
                        i_is_vx ? 64'(i_scalar[7:0]) : 64'(i_vs1.e8[i]));
          o_cmp[i] = ext[64];
          if ((i_elem_base + VL_W'(i)) < i_vl) o_res.e8[i] = ext[7:0];
        end
      end
      EW16 : begin
        for (int i = 0; i < 4; i++) begin
          ext = elem_op(i_op, 64'(i_vs2.e16[i]),
                        i_is_vx ? 64'(i_scalar[15:0]) : 64'(i_vs1.e16[i]));
          o_cmp[i] = ext[64];
          if ((i_elem_base + VL_W'(i)) < i_vl) o_res.e16[i] = ext[15:0];
        end
      end
      EW32 : begin
        for (int i = 0; i < 2; i++) begin
          ext = elem_op(i_op, 64'(i_vs2.e32[i]),
                        i_is_vx ? 64'(i_scalar[31:0]) : 64'(i_vs1.e32[i]));
          o_cmp[i] = ext[64];
          if ((i_elem_base + VL_W'(i)) < i_vl) o_res.e32[i] = ext[31:0];
        end
      end
      EW64 : begin
        ext = elem_op(i_op, i_vs2.e64, i_is_vx ? i_scalar : i_vs1.e64);
        o_cmp[0] = ext[64];
        if (i_elem_base < i_vl) o_res.e64 = ext[63:0];
      end
    endcase
  end

endmodule

// File: verilog/valu_mask_pack.sv
/*
 * Mask result assembly from lane compare bits, accumulated across steps
 */
module valu_mask_pack #(
  parameter int STEP_NUM = 2
) (
  input  logic                               i_clk,
  input  logic                               i_reset_n,
  input  logic                               i_valid,     // Mask step in EX1
  input  valu_pkg::sew_t                     i_sew,
  input  logic [valu_pkg::VL_W-1:0]          i_vl,
  input  logic [valu_pkg::STEP_W-1:0]        i_step,
  input  logic [valu_pkg::LANE_NUM-1:0][7:0] i_lane_cmp,
  input  logic [valu_pkg::DLEN_W-1:0]        i_old,       // Slice 0 of old vd
  output logic [valu_pkg::DLEN_W-1:0]        o_mask
);
  import valu_pkg::*;

  logic [DLEN_W-1:0]     r_acc;        // Mask bits of earlier steps
  logic [LANE_NUM*8-1:0] w_step_bits;  // This step's compares in element order

  always_comb begin
    int n;     // Elements per lane
    int e;     // Elements per step
    int base;  // First mask bit of this step
    n    = 8 >> i_sew;
    e    = n * LANE_NUM;
    base = int'(i_step) * e;
    w_step_bits = '0;
    for (int l = 0; l < LANE_NUM; l++) begin
      for (int j = 0; j < 8; j++) begin
        if (j < n) w_step_bits[l*n + j] = i_lane_cmp[l][j];
      end
    end
    for (int i = 0; i < DLEN_W; i++) begin
      if (i < base) begin
        o_mask[i] = r_acc[i];
      end else if (i < base + e) begin
        o_mask[i] = (i < int'(i_vl)) ? w_step_bits[i - base] : i_old[i];  // Tail keeps old
      end else begin
        o_mask[i] = i_old[i];  // Beyond this step
      end
    end
  end

  generate
    if (STEP_NUM > 1) begin : g_acc
      always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_acc <= '0;
        end else if (i_valid) begin
          r_acc <= o_mask;
        end
      end
    end else begin : g_no_acc
      assign r_acc = '0;  // Whole mask fits in one step
    end
  endgenerate

endmodule

// File: verilog/valu_pipe.sv
/*
 * Three-stage integer vector ALU pipe, EX0 decode/read, EX1 compute, EX2 write
 * Commit flush kills EX0 and EX1, single write port and done report
 */
module valu_pipe #(
  parameter int STEP_NUM = 2
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  valu_pkg::issue_t            i_issue,
  input  logic                        i_commit_flush,
  output valu_pkg::vreg_rd_req_t      o_vs1_rd,
  output valu_pkg::vreg_rd_req_t      o_vs2_rd,
  output valu_pkg::vreg_rd_req_t      o_vd_old_rd,
  input  logic [valu_pkg::DLEN_W-1:0] i_vs1_data,     // Returned in the issue cycle
  input  logic [valu_pkg::DLEN_W-1:0] i_vs2_data,
  input  logic [valu_pkg::DLEN_W-1:0] i_vd_old_data,
  output valu_pkg::vreg_wr_t          o_vreg_wr,
  output valu_pkg::done_rpt_t         o_done
);
  import valu_pkg::*;

  typedef struct packed {
    alu_op_t op;
    logic    is_mask;
    logic    is_vx;
  } ex_ctrl_t;

  ex_ctrl_t                 w_ex0_ctrl;
  issue_t                   r_ex1_issue;
  ex_ctrl_t                 r_ex1_ctrl;
  logic [DLEN_W-1:0]        r_ex1_vs1;
  logic [DLEN_W-1:0]        r_ex1_vs2;
  logic [DLEN_W-1:0]        r_ex1_old;
  logic [DLEN_W-1:0]        w_ex1_res;   // Lane results, tail merged
  logic [DLEN_W-1:0]        w_ex1_mask;  // Packed mask register value
  logic [LANE_NUM-1:0][7:0] w_ex1_cmp;
  issue_t                   r_ex2_issue;
  ex_ctrl_t                 r_ex2_ctrl;
  logic [DLEN_W-1:0]        r_ex2_data;
  logic                     w_ex2_last;  // Last step of its instruction

  //--------------------------------------------------------------------------
  // EX0 decode and register reads
  //--------------------------------------------------------------------------
  valu_decoder u_decoder (
    .i_inst    (i_issue.inst),
    .o_op      (w_ex0_ctrl.op),
    .o_is_mask (w_ex0_ctrl.is_mask),
    .o_is_vx   (w_ex0_ctrl.is_vx)
  );

  always_comb begin
    o_vs1_rd.valid    = i_issue.valid & ~w_ex0_ctrl.is_vx;  // Scalar rides in issue
    o_vs1_rd.rnid     = i_issue.vs1_rnid;
    o_vs1_rd.pos      = i_issue.step;
    o_vs2_rd.valid    = i_issue.valid;
    o_vs2_rd.rnid     = i_issue.vs2_rnid;
    o_vs2_rd.pos      = i_issue.step;
    o_vd_old_rd.valid = i_issue.valid;
    o_vd_old_rd.rnid  = i_issue.vd_rnid;
    o_vd_old_rd.pos   = w_ex0_ctrl.is_mask ? '0 : i_issue.step;  // Mask sits in slice 0
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue       <= i_issue;
      r_ex1_issue.valid <= i_issue.valid & ~i_commit_flush;
      r_ex1_ctrl        <= w_ex0_ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_vs1 <= i_vs1_data;
    r_ex1_vs2 <= i_vs2_data;
    r_ex1_old <= i_vd_old_data;
  end

  //--------------------------------------------------------------------------
  // EX1 lanes and mask assembly
  //--------------------------------------------------------------------------
  for (genvar l = 0; l < LANE_NUM; l++) begin : g_lane
    logic [VL_W-1:0] w_elem_base;
    // 8 byte slots per lane, scaled down by element width
    assign w_elem_base = VL_W'((int'(r_ex1_issue.step) * LANE_NUM + l) * 8) >> r_ex1_issue.sew;

    valu_lane u_lane (
      .i_op        (r_ex1_ctrl.op),
      .i_sew       (r_ex1_issue.sew),
      .i_vs1       (r_ex1_vs1[l*LANE_W +: LANE_W]),
      .i_vs2       (r_ex1_vs2[l*LANE_W +: LANE_W]),
      .i_old       (r_ex1_old[l*LANE_W +: LANE_W]),
      .i_scalar    (r_ex1_issue.scalar),
      .i_is_vx     (r_ex1_ctrl.is_vx),
      .i_elem_base (w_elem_base),
      .i_vl        (r_ex1_issue.vl),
      .o_res       (w_ex1_res[l*LANE_W +: LANE_W]),
      .o_cmp       (w_ex1_cmp[l])
    );
  end

  valu_mask_pack #(
    .STEP_NUM (STEP_NUM)
  ) u_mask_pack (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid    (r_ex1_issue.valid & r_ex1_ctrl.is_mask),
    .i_sew      (r_ex1_issue.sew),
    .i_vl       (r_ex1_issue.vl),
    .i_step     (r_ex1_issue.step),
    .i_lane_cmp (w_ex1_cmp),
    .i_old      (r_ex1_old),
    .o_mask     (w_ex1_mask)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
    end else begin
      r_ex2_issue       <= r_ex1_issue;
      r_ex2_issue.valid <= r_ex1_issue.valid & ~i_commit_flush;  // EX2 itself never killed
      r_ex2_ctrl        <= r_ex1_ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_data <= r_ex1_ctrl.is_mask ? w_ex1_mask : w_ex1_res;
  end

  //--------------------------------------------------------------------------
  // EX2 write-back and done
  //--------------------------------------------------------------------------
  assign w_ex2_last = (r_ex2_issue.step == STEP_W'(STEP_NUM - 1));

  always_comb begin
    // Mask ops write once on the last step, OP_NONE only reports done
    o_vreg_wr.valid = r_ex2_issue.valid & (r_ex2_ctrl.op != OP_NONE) &
                      (~r_ex2_ctrl.is_mask | w_ex2_last);
    o_vreg_wr.rnid  = r_ex2_issue.vd_rnid;
    o_vreg_wr.pos   = r_ex2_ctrl.is_mask ? '0 : r_ex2_issue.step;
    o_vreg_wr.data  = r_ex2_data;
    o_done.valid    = r_ex2_issue.valid & w_ex2_last;
    o_done.cmt_id   = r_ex2_issue.cmt_id;
  end

endmodule

// File: verif/valu_pipe_properties.sv
/*
 * Timing assertions of the vector ALU pipe, bound into valu_pipe
 */
module valu_pipe_properties #(
  parameter int STEP_NUM = 2
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input valu_pkg::issue_t    i_issue,
  input logic                i_commit_flush,
  input valu_pkg::vreg_wr_t  o_vreg_wr,
  input valu_pkg::done_rpt_t o_done
);
  timeunit 1ns;
  timeprecision 1ps;
  import valu_pkg::*;

  logic w_last;  // Valid issue of a last step

  assign w_last = i_issue.valid && (i_issue.step == STEP_W'(STEP_NUM - 1));

  // ------------------------------------------------------------------------
  // Reset and latency
  // ------------------------------------------------------------------------
  a_reset_quiet : assert property (@(posedge i_clk)
    !i_reset_n |-> !o_vreg_wr.valid && !o_done.valid)
    else $error("write or done valid during reset");

  // Unflushed last step reports done two cycles later, in order
  a_done_latency : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_last && !i_commit_flush) ##1 !i_commit_flush |=>
      o_done.valid && (o_done.cmt_id == $past(i_issue.cmt_id, 2)))
    else $error("done report missing or late");

  a_done_last_only : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done.valid |-> $past(w_last, 2))
    else $error("done report for a step that was not the last");

  // Neither the issue cycle nor the EX1 cycle may have flushed a write
  a_wr_from_issue : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_vreg_wr.valid |->
      $past(i_issue.valid, 2) && !$past(i_commit_flush, 2) && !$past(i_commit_flush, 1))
    else $error("write without a matching issue");

endmodule

bind valu_pipe valu_pipe_properties #(.STEP_NUM(STEP_NUM)) u_properties (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_issue        (i_issue),
  .i_commit_flush (i_commit_flush),
  .o_vreg_wr      (o_vreg_wr),
  .o_done         (o_done)
);

// File: verif/tb_valu_pipe.sv
/*
 * Testbench for the vector ALU pipe: clock, reset, register file model,
 * LCG stimulus, queue-based reference model and immediate value checks
 */
module tb_valu_pipe;
  timeunit 1ns;
  timeprecision 1ps;
  import valu_pkg::*;

  localparam int STEP_NUM = 2;

  typedef struct packed {
    logic                wr_valid;
    logic [RNID_W-1:0]   rnid;
    logic [STEP_W-1:0]   pos;
    logic [DLEN_W-1:0]   data;
    logic                done_valid;
    logic [CMT_ID_W-1:0] cmt_id;
  } exp_t;

  logic              i_clk = 1'b0;
  logic              i_reset_n;
  issue_t            i_issue;
  logic              i_commit_flush;
  vreg_rd_req_t      o_vs1_rd, o_vs2_rd, o_vd_old_rd;
  logic [DLEN_W-1:0] i_vs1_data, i_vs2_data, i_vd_old_data;
  vreg_wr_t          o_vreg_wr;
  done_rpt_t         o_done;

  logic [DLEN_W-1:0]   rf [64][STEP_NUM];  // Register file, rnid by slice
  exp_t                exp_q[$];           // One entry per issue cycle
  logic [31:0]         seed = 32'h3f86_e11a;
  logic [DLEN_W-1:0]   mask_acc = '0;      // Model of the step accumulator
  logic [CMT_ID_W-1:0] cmt_cnt = '0;

  always #5 i_clk = ~i_clk;

  // Combinational read return, same cycle as the request
  assign i_vs1_data    = rf[o_vs1_rd.rnid][o_vs1_rd.pos];
  assign i_vs2_data    = rf[o_vs2_rd.rnid][o_vs2_rd.pos];
  assign i_vd_old_data = rf[o_vd_old_rd.rnid][o_vd_old_rd.pos];

  valu_pipe #(.STEP_NUM(STEP_NUM)) u_valu_pipe (.*);

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // RVV OP-V word with vm=1
  function automatic logic [31:0] build_inst(input alu_op_t op, input logic vx);
    logic [5:0] f6;
    logic [2:0] f3;
    f3 = vx ? FUNCT3_OPIVX : FUNCT3_OPIVV;
    case (op)
      OP_ADD   : f6 = FUNCT6_VADD;
      OP_SUB   : f6 = FUNCT6_VSUB;
      OP_AND   : f6 = FUNCT6_VAND;
      OP_OR    : f6 = FUNCT6_VOR;
      OP_XOR   : f6 = FUNCT6_VXOR;
      OP_MSEQ  : f6 = FUNCT6_VMSEQ;
      OP_MSNE  : f6 = FUNCT6_VMSNE;
      OP_MSLTU : f6 = FUNCT6_VMSLTU;
      default  : begin
        f6 = 6'b000000;
        f3 = 3'b010;  // OPMVV, not handled here
      end
    endcase
    return {f6, 1'b1, 5'd2, 5'd1, f3, 5'd3, 7'h57};
  endfunction

  // Bit 64 is the compare outcome
  function automatic logic [64:0] elem_result(input alu_op_t op, input logic [63:0] a,
                                              input logic [63:0] b, input int w);
    logic [63:0] m;
    logic [64:0] r;
    m = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    r = '0;
    case (op)
      OP_ADD   : r[63:0] = (a + b) & m;
      OP_SUB   : r[63:0] = (a - b) & m;
      OP_AND   : r[63:0] = a & b;
      OP_OR    : r[63:0] = a | b;
      OP_XOR   : r[63:0] = a ^ b;
      OP_MSEQ  : r[64] = (a == b);
      OP_MSNE  : r[64] = (a != b);
      OP_MSLTU : r[64] = (a < b);
      default  : r = '0;
    endcase
    return r;
  endfunction

  function automatic exp_t predict(input issue_t iss, input alu_op_t op, input logic vx);
    exp_t              e;
    logic              is_mask;
    logic [DLEN_W-1:0] vs1, vs2, old, res, mask;
    logic [63:0]       m, a, b;
    logic [64:0]       r;
    int                w, ne, base;
    is_mask = (op == OP_MSEQ) || (op == OP_MSNE) || (op == OP_MSLTU);
    w    = 8 << iss.sew;
    ne   = DLEN_W / w;                       // Elements per step
    base = int'(iss.step) * ne;
    m    = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    vs1  = rf[iss.vs1_rnid][iss.step];
    vs2  = rf[iss.vs2_rnid][iss.step];
    old  = rf[iss.vd_rnid][is_mask ? 0 : iss.step];  // Mask lives in slice 0
    res  = old;
    mask = old;
    for (int k = 0; k < base; k++) mask[k] = mask_acc[k];
    for (int i = 0; i < ne; i++) begin
      a = 64'(vs2 >> (i * w)) & m;
      b = vx ? (iss.scalar & m) : (64'(vs1 >> (i * w)) & m);
      r = elem_result(op, a, b, w);
      if (base + i < int'(iss.vl)) begin
        for (int k = 0; k < w; k++) res[i*w + k] = r[k];
        mask[base + i] = r[64];
      end
    end
    if (is_mask) mask_acc = mask;
    e.done_valid = (iss.step == STEP_W'(STEP_NUM - 1));
    e.wr_valid   = (op != OP_NONE) && (!is_mask || e.done_valid);
    e.rnid       = iss.vd_rnid;
    e.pos        = is_mask ? '0 : iss.step;
    e.data       = is_mask ? mask : res;
    e.cmt_id     = iss.cmt_id;
    return e;
  endfunction

  task automatic report_value(input string name, input logic [DLEN_W-1:0] got,
                              input logic [DLEN_W-1:0] want);
    $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
    $display("TB FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_outputs(input exp_t e);
    assert (o_vreg_wr.valid == e.wr_valid)
      else report_value("o_vreg_wr.valid", o_vreg_wr.valid, e.wr_valid);
    if (e.wr_valid) begin
      assert (o_vreg_wr.rnid == e.rnid) else report_value("o_vreg_wr.rnid", o_vreg_wr.rnid, e.rnid);
      assert (o_vreg_wr.pos == e.pos) else report_value("o_vreg_wr.pos", o_vreg_wr.pos, e.pos);
      assert (o_vreg_wr.data == e.data) else report_value("o_vreg_wr.data", o_vreg_wr.data, e.data);
    end
    assert (o_done.valid == e.done_valid)
      else report_value("o_done.valid", o_done.valid, e.done_valid);
    if (e.done_valid) begin
      assert (o_done.cmt_id == e.cmt_id) else report_value("o_done.cmt_id", o_done.cmt_id, e.cmt_id);
    end
  endtask

  // One clock: check the EX2 outputs, then drive the next issue
  task automatic step_cycle(input issue_t iss, input alu_op_t op, input logic vx,
                            input logic flush);
    exp_t e;
    @(negedge i_clk);
    if (exp_q.size() == 2) check_outputs(exp_q.pop_front());
    i_issue        = iss;
    i_commit_flush = flush;
    e = iss.valid ? predict(iss, op, vx) : '0;
    if (flush) begin
      e = '0;                             // Kills EX0
      if (exp_q.size() > 0) exp_q[0] = '0;  // and EX1
    end
    exp_q.push_back(e);
    #1;
    assert (o_vs1_rd.valid == (iss.valid & ~vx))
      else report_value("o_vs1_rd.valid", o_vs1_rd.valid, iss.valid & ~vx);
    assert (o_vs2_rd.valid == iss.valid)
      else report_value("o_vs2_rd.valid", o_vs2_rd.valid, iss.valid);
    assert (o_vd_old_rd.valid == iss.valid)
      else report_value("o_vd_old_rd.valid", o_vd_old_rd.valid, iss.valid);
  endtask

  task automatic idle(input logic flush);
    step_cycle('0, OP_NONE, 1'b0, flush);
  endtask

  // flush_at names the cycle that flushes, STEP_NUM is the cycle after the last step
  task automatic run_instr(input alu_op_t op, input logic vx, input sew_t sew,
                           input logic same_src, input int flush_at);
    issue_t iss;
    int     ne;
    ne = DLEN_W / (8 << sew);
    cmt_cnt++;
    iss          = '0;
    iss.valid    = 1'b1;
    iss.inst     = build_inst(op, vx);
    iss.cmt_id   = cmt_cnt;
    iss.vs1_rnid = RNID_W'(lcg_next());
    iss.vs2_rnid = same_src ? iss.vs1_rnid : RNID_W'(lcg_next());
    iss.vd_rnid  = RNID_W'(lcg_next());
    iss.scalar   = {lcg_next(), lcg_next()};
    iss.sew      = sew;
    iss.vl       = VL_W'(lcg_next() % (2 * ne * STEP_NUM / 2 + 2));
    for (int s = 0; s < STEP_NUM; s++) begin
      iss.step = STEP_W'(s);
      step_cycle(iss, op, vx, flush_at == s);
    end
    if (flush_at == STEP_NUM) idle(1'b1);
    else if (lcg_next() % 4 == 0) idle(1'b0);
  endtask

  initial begin
    int n;
    logic pending;
    i_issue        = '0;
    i_commit_flush = 1'b0;
    i_reset_n      = 1'b0;
    for (int r = 0; r < 64; r++)
      for (int s = 0; s < STEP_NUM; s++)
        rf[r][s] = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // Element-wise ops in both forms at every width
    for (int op = OP_ADD; op <= OP_XOR; op++)
      for (int vx = 0; vx < 2; vx++)
        for (int sw = 0; sw < 4; sw++)
          run_instr(alu_op_t'(op), vx[0], sew_t'(sw), 1'b0, -1);
    // Compares, same source registers give equal elements
    for (int op = OP_MSEQ; op <= OP_MSLTU; op++)
      for (int vx = 0; vx < 2; vx++)
        for (int sw = 0; sw < 4; sw++)
          for (int rep = 0; rep < 2; rep++)
            run_instr(alu_op_t'(op), vx[0], sew_t'(sw), rep[0], -1);
    // Commit flush at each position
    run_instr(OP_ADD, 1'b0, EW32, 1'b0, 0);
    run_instr(OP_XOR, 1'b0, EW8, 1'b0, 1);
    run_instr(OP_SUB, 1'b1, EW16, 1'b0, 2);
    run_instr(OP_OR, 1'b0, EW64, 1'b0, -1);
    // Unknown encoding
    run_instr(OP_NONE, 1'b0, EW8, 1'b0, -1);
    run_instr(OP_AND, 1'b1, EW8, 1'b0, -1);

    n = 0;
    pending = 1'b1;
    while (pending && n < 8) begin
      idle(1'b0);
      n++;
      pending = 1'b0;
      foreach (exp_q[i]) pending |= exp_q[i].wr_valid | exp_q[i].done_valid;
    end
    if (pending) begin
      $display("Timeout while waiting for the last writes to drain");
      $display("TB FAILED");
      $fatal(1, "drain timeout");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: vlog.f
verilog/valu_pkg.sv
verilog/valu_decoder.sv
verilog/valu_lane.sv
verilog/valu_mask_pack.sv
verilog/valu_pipe.sv
verif/valu_pipe_properties.sv
verif/tb_valu_pipe.sv

// File: run.sh
#!/bin/sh
# Compile and run the vector ALU pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_valu_pipe -f vlog.f -o sim_valu

./obj_dir/sim_valu > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
grep -q "TB PASSED" sim.log
